// ==== verilog/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and address width
`define XLEN        32

// Register file geometry
`define REG_ADDR_W  5
`define NUM_REGS    32

// First fetch address after reset
`define RESET_PC    32'h1c00_0000

// Opcode field inside the instruction word
`define OPC_MSB     31
`define OPC_LSB     26

`endif

// ==== verilog/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    // Primary opcode, instr[31:26]
    typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
        OPC_ADD   = 6'h01,
        OPC_SUB   = 6'h02,
        OPC_AND   = 6'h03,
        OPC_OR    = 6'h04,
        OPC_XOR   = 6'h05,
        OPC_SLT   = 6'h06,
        OPC_ADDI  = 6'h08,
        OPC_LU12I = 6'h0a,
        OPC_BEQ   = 6'h10,
        OPC_BNE   = 6'h11,
        OPC_B     = 6'h12,
        OPC_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6  // Operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        CTRL_BOOT = 2'd0,
        CTRL_RUN  = 2'd1,
        CTRL_HALT = 2'd2
    } ctrl_state_e;

endpackage

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/1ns

module pipe_ctrl (
    input  logic clk,
    input  logic arst_n_i,

    input  logic branch_taken_i,  // From execute
    input  logic halt_seen_i,     // HALT in execute this cycle

    output logic fetch_en_o,
    output logic redirect_o,
    output logic dec_valid_o,
    output logic ex_valid_o,
    output logic halted_o
);

    core_pkg::ctrl_state_e state_q;
    logic dec_valid_q;
    logic ex_valid_q;
    logic flush;

    // Both a taken branch and a HALT kill the two younger slots
    assign flush = branch_taken_i | halt_seen_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= core_pkg::CTRL_BOOT;
            dec_valid_q <= 1'b0;
            ex_valid_q  <= 1'b0;
        end else begin
            case (state_q)
                core_pkg::CTRL_BOOT: state_q <= core_pkg::CTRL_RUN;
                core_pkg::CTRL_RUN: begin
                    if (halt_seen_i) begin
                        state_q <= core_pkg::CTRL_HALT;
                    end
                end
                core_pkg::CTRL_HALT: state_q <= core_pkg::CTRL_HALT;  // Until reset
                default: state_q <= core_pkg::CTRL_BOOT;
            endcase

            // A request this cycle means an instruction in decode next cycle
            dec_valid_q <= fetch_en_o & ~flush;
            ex_valid_q  <= dec_valid_q & ~flush;
        end
    end

    assign fetch_en_o  = (state_q == core_pkg::CTRL_RUN);
    assign redirect_o  = branch_taken_i;
    assign dec_valid_o = dec_valid_q;
    assign ex_valid_o  = ex_valid_q;
    assign halted_o    = (state_q == core_pkg::CTRL_HALT);

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             arst_n_i,

    input  logic             fetch_en_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] target_i,   // Branch target from execute

    output logic             imem_req_o,
    output logic [`XLEN-1:0] imem_addr_o,
    output logic [`XLEN-1:0] dec_pc_o    // PC of the word now on imem_rdata_i
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] dec_pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (fetch_en_i) begin
            pc_q <= pc_q + `XLEN'd4;
        end
    end

    // Memory answers one cycle later, so the PC follows it by one cycle
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            dec_pc_q <= pc_q;
        end
    end

    assign imem_req_o  = fetch_en_i;
    assign imem_addr_o = pc_q;
    assign dec_pc_o    = dec_pc_q;

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,

    input  logic                    valid_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        instr_i,

    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,

    input  logic                    ex_valid_i,
    output logic [`XLEN-1:0]        ex_pc_o,
    output core_pkg::opcode_e       ex_op_o,
    output core_pkg::alu_op_e       ex_alu_op_o,
    output logic [`XLEN-1:0]        ex_a_o,
    output logic [`XLEN-1:0]        ex_b_o,
    output logic [`XLEN-1:0]        ex_cmp_o,     // Compared against ex_a_o by branches
    output logic [`XLEN-1:0]        ex_offset_o,
    output logic [`REG_ADDR_W-1:0]  ex_rd_o,
    output logic                    ex_wen_o
);

    core_pkg::opcode_e      opc;
    core_pkg::alu_op_e      alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rj;
    logic [`REG_ADDR_W-1:0] rk;
    logic [`XLEN-1:0]       opnd_b;
    logic [`XLEN-1:0]       br_offset;
    logic                   is_branch;
    logic                   wen;
    logic                   ex_wen_q;

    assign opc = core_pkg::opcode_e'(instr_i[`OPC_MSB:`OPC_LSB]);
    assign rd  = instr_i[4:0];
    assign rj  = instr_i[9:5];
    assign rk  = instr_i[14:10];

    assign is_branch  = opc inside {core_pkg::OPC_BEQ, core_pkg::OPC_BNE, core_pkg::OPC_B};
    assign rs1_addr_o = rj;
    assign rs2_addr_o = is_branch ? rd : rk;  // Branches compare rj with rd

    // offs16 scaled to a byte offset
    assign br_offset = {{(`XLEN-18){instr_i[25]}}, instr_i[25:10], 2'b00};

    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        opnd_b = rs2_data_i;
        wen    = 1'b1;
        case (opc)
            core_pkg::OPC_ADD: alu_op = core_pkg::ALU_ADD;
            core_pkg::OPC_SUB: alu_op = core_pkg::ALU_SUB;
            core_pkg::OPC_AND: alu_op = core_pkg::ALU_AND;
            core_pkg::OPC_OR:  alu_op = core_pkg::ALU_OR;
            core_pkg::OPC_XOR: alu_op = core_pkg::ALU_XOR;
            core_pkg::OPC_SLT: alu_op = core_pkg::ALU_SLT;
            core_pkg::OPC_ADDI: begin
                opnd_b = {{(`XLEN-12){instr_i[21]}}, instr_i[21:10]};  // si12
            end
            core_pkg::OPC_LU12I: begin
                alu_op = core_pkg::ALU_PASS_B;
                opnd_b = {instr_i[24:5], 12'h000};
            end
            default: wen = 1'b0;  // Branches, HALT and unknown opcodes
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_wen_q <= 1'b0;
        end else begin
            ex_wen_q <= valid_i & wen & (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            ex_pc_o     <= pc_i;
            ex_op_o     <= opc;
            ex_alu_op_o <= alu_op;
            ex_a_o      <= rs1_data_i;
            ex_b_o      <= opnd_b;
            ex_cmp_o    <= rs2_data_i;
            ex_offset_o <= br_offset;
            ex_rd_o     <= rd;
        end
    end

    // A squashed execute slot never claims a write
    assign ex_wen_o = ex_wen_q & ex_valid_i;

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,

    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o,

    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i
);

    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];  // r0 has no storage

    // Same-cycle write wins, so decode sees the result of execute
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   arst_n_i,

    input  logic                   valid_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  core_pkg::opcode_e      op_i,
    input  core_pkg::alu_op_e      alu_op_i,
    input  logic [`XLEN-1:0]       a_i,
    input  logic [`XLEN-1:0]       b_i,
    input  logic [`XLEN-1:0]       cmp_i,
    input  logic [`XLEN-1:0]       offset_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic                   wen_i,

    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]       rf_wdata_o,
    output logic                   branch_taken_o,
    output logic [`XLEN-1:0]       branch_target_o,
    output logic                   halt_seen_o,

    output logic                   debug_commit_valid_o,
    output logic [`XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata_o
);

    logic [`XLEN-1:0] alu_res;
    logic             br_cond;

    always_comb begin
        case (alu_op_i)
            core_pkg::ALU_SUB:    alu_res = a_i - b_i;
            core_pkg::ALU_AND:    alu_res = a_i & b_i;
            core_pkg::ALU_OR:     alu_res = a_i | b_i;
            core_pkg::ALU_XOR:    alu_res = a_i ^ b_i;
            core_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            core_pkg::ALU_PASS_B: alu_res = b_i;
            default:              alu_res = a_i + b_i;  // ADD and ADDI
        endcase
    end

    always_comb begin
        case (op_i)
            core_pkg::OPC_BEQ: br_cond = (a_i == cmp_i);
            core_pkg::OPC_BNE: br_cond = (a_i != cmp_i);
            core_pkg::OPC_B:   br_cond = 1'b1;
            default:           br_cond = 1'b0;
        endcase
    end

    assign branch_taken_o  = valid_i & br_cond;
    assign branch_target_o = pc_i + offset_i;  // Relative to the branch itself
    assign halt_seen_o     = valid_i & (op_i == core_pkg::OPC_HALT);

    assign rf_we_o    = valid_i & wen_i;
    assign rf_waddr_o = rd_i;
    assign rf_wdata_o = alu_res;

    // Commit record, one cycle behind execute
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            debug_commit_valid_o <= 1'b0;
            debug_wb_rf_wen_o    <= 4'h0;
        end else begin
            debug_commit_valid_o <= valid_i;
            debug_wb_rf_wen_o    <= rf_we_o ? 4'hf : 4'h0;
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc_o       <= pc_i;
        debug_wb_rf_wnum_o  <= rf_we_o ? rd_i : '0;
        debug_wb_rf_wdata_o <= rf_we_o ? alu_res : '0;
    end

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_top (
    input  logic                   clk,
    input  logic                   arst_n_i,

    // Instruction memory
    output logic                   imem_req_o,
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [`XLEN-1:0]       imem_rdata_i,

    // Retire trace
    output logic                   debug_commit_valid_o,
    output logic [`XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata_o,

    output logic                   halted_o
);

    logic                   fetch_en;
    logic                   redirect;
    logic                   dec_valid;
    logic                   ex_valid;
    logic                   branch_taken;
    logic                   halt_seen;
    logic [`XLEN-1:0]       branch_target;
    logic [`XLEN-1:0]       dec_pc;

    // Decode <-> register file
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    // Decode -> execute
    logic [`XLEN-1:0]       ex_pc;
    core_pkg::opcode_e      ex_op;
    core_pkg::alu_op_e      ex_alu_op;
    logic [`XLEN-1:0]       ex_a;
    logic [`XLEN-1:0]       ex_b;
    logic [`XLEN-1:0]       ex_cmp;
    logic [`XLEN-1:0]       ex_offset;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic                   ex_wen;

    // Execute -> register file write port
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;

    pipe_ctrl u_pipe_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .branch_taken_i (branch_taken),
        .halt_seen_i    (halt_seen),
        .fetch_en_o     (fetch_en),
        .redirect_o     (redirect),
        .dec_valid_o    (dec_valid),
        .ex_valid_o     (ex_valid),
        .halted_o       (halted_o)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .fetch_en_i  (fetch_en),
        .redirect_i  (redirect),
        .target_i    (branch_target),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .dec_pc_o    (dec_pc)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (dec_valid),
        .pc_i        (dec_pc),
        .instr_i     (imem_rdata_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .ex_valid_i  (ex_valid),
        .ex_pc_o     (ex_pc),
        .ex_op_o     (ex_op),
        .ex_alu_op_o (ex_alu_op),
        .ex_a_o      (ex_a),
        .ex_b_o      (ex_b),
        .ex_cmp_o    (ex_cmp),
        .ex_offset_o (ex_offset),
        .ex_rd_o     (ex_rd),
        .ex_wen_o    (ex_wen)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    exec_unit u_exec_unit (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .valid_i              (ex_valid),
        .pc_i                 (ex_pc),
        .op_i                 (ex_op),
        .alu_op_i             (ex_alu_op),
        .a_i                  (ex_a),
        .b_i                  (ex_b),
        .cmp_i                (ex_cmp),
        .offset_i             (ex_offset),
        .rd_i                 (ex_rd),
        .wen_i                (ex_wen),
        .rf_we_o              (rf_we),
        .rf_waddr_o           (rf_waddr),
        .rf_wdata_o           (rf_wdata),
        .branch_taken_o       (branch_taken),
        .branch_target_o      (branch_target),
        .halt_seen_o          (halt_seen),
        .debug_commit_valid_o (debug_commit_valid_o),
        .debug_wb_pc_o        (debug_wb_pc_o),
        .debug_wb_rf_wen_o    (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o   (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o  (debug_wb_rf_wdata_o)
    );

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int half_period = 20  // 40 ns clock
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #half_period clk_o = ~clk_o;

endmodule

// ==== verif/core_props.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_props (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic                   imem_req_i,
    input logic                   halted_i,
    input logic                   commit_valid_i,
    input logic [3:0]             wb_wen_i,
    input logic [`REG_ADDR_W-1:0] wb_wnum_i
);

    // A halted core stays off the instruction bus
    halt_stops_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
        halted_i |-> !imem_req_i)
        else $error("Instruction fetch requested while halted");

    write_has_reg: assert property (@(posedge clk) disable iff (!arst_n_i)
        (commit_valid_i && (wb_wen_i != 4'h0)) |-> (wb_wnum_i != '0))
        else $error("Register write commit names r0");

    no_commit_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !commit_valid_i)
        else $error("Commit seen while reset is asserted");

endmodule

bind core_top core_props u_core_props (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .imem_req_i     (imem_req_o),
    .halted_i       (halted_o),
    .commit_valid_i (debug_commit_valid_o),
    .wb_wen_i       (debug_wb_rf_wen_o),
    .wb_wnum_i      (debug_wb_rf_wnum_o)
);

// ==== verif/core_tb.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_tb;

    localparam int          max_cycles = 1500;
    localparam logic [31:0] lfsr_seed  = 32'h5a32_af7e;

    logic                   clk;
    logic                   arst_n_i;
    logic                   imem_req_o;
    logic [`XLEN-1:0]       imem_addr_o;
    logic [`XLEN-1:0]       imem_rdata_i;
    logic                   debug_commit_valid_o;
    logic [`XLEN-1:0]       debug_wb_pc_o;
    logic [3:0]             debug_wb_rf_wen_o;
    logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum_o;
    logic [`XLEN-1:0]       debug_wb_rf_wdata_o;
    logic                   halted_o;

    logic [31:0] prog_mem [0:63];
    int          prog_len;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    logic        req_q;
    logic [31:0] addr_q;

    // Expected commit list from the reference model
    logic [31:0] exp_pc[$];
    logic [31:0] exp_wen[$];
    logic [31:0] exp_wnum[$];
    logic [31:0] exp_wdata[$];
    logic [31:0] exp_gap[$];    // Cycles since previous commit, 0 for the first
    bit          exp_halt[$];

    tb_clkgen u_clkgen (.clk_o(clk));

    core_top u_core_top (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .imem_req_o           (imem_req_o),
        .imem_addr_o          (imem_addr_o),
        .imem_rdata_i         (imem_rdata_i),
        .debug_commit_valid_o (debug_commit_valid_o),
        .debug_wb_pc_o        (debug_wb_pc_o),
        .debug_wb_rf_wen_o    (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o   (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o  (debug_wb_rf_wdata_o),
        .halted_o             (halted_o)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else report_fail($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // Unused words decode as an undefined opcode
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - `RESET_PC;
        if ((addr >= `RESET_PC) && ((offs >> 2) < 32'(prog_len))) begin
            return prog_mem[offs[7:2]];
        end
        return {6'h3e, addr[25:0] ^ {20'h0, addr[31:26]}};
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] op, input int rd, input int rj,
                                          input int rk);
        return {op, 11'd0, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_i(input int rd, input int rj, input int imm);
        return {core_pkg::OPC_ADDI, 4'd0, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_u(input int rd, input int imm);
        return {core_pkg::OPC_LU12I, 1'b0, imm[19:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_br(input logic [5:0] op, input int rj, input int rd,
                                           input int off);
        return {op, off[15:0], rj[4:0], rd[4:0]};
    endfunction

    task automatic emit(input logic [31:0] w);
        if (prog_len >= 64) begin
            report_fail("Program does not fit in the instruction memory model");
        end else begin
            prog_mem[prog_len[5:0]] = w;
            prog_len++;
        end
    endtask

    // Walks the program by the ISA rules and fills the expected commit list
    task automatic run_model;
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] res;
        logic [5:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        wr;
        logic        taken;
        logic        prev_taken;
        bit          halt_hit;
        int          steps;
        foreach (regs[k]) regs[k] = '0;
        exp_pc.delete();
        exp_wen.delete();
        exp_wnum.delete();
        exp_wdata.delete();
        exp_gap.delete();
        exp_halt.delete();
        pc         = `RESET_PC;
        prev_taken = 1'b0;
        halt_hit   = 1'b0;
        steps      = 0;
        while (!halt_hit && (steps < 64)) begin
            instr = mem_word(pc);
            opc   = instr[31:26];
            rd    = instr[4:0];
            rj    = instr[9:5];
            rk    = instr[14:10];
            wr    = 1'b1;
            taken = 1'b0;
            res   = '0;
            case (opc)
                core_pkg::OPC_ADD:   res = regs[rj] + regs[rk];
                core_pkg::OPC_SUB:   res = regs[rj] - regs[rk];
                core_pkg::OPC_AND:   res = regs[rj] & regs[rk];
                core_pkg::OPC_OR:    res = regs[rj] | regs[rk];
                core_pkg::OPC_XOR:   res = regs[rj] ^ regs[rk];
                core_pkg::OPC_SLT:   res = ($signed(regs[rj]) < $signed(regs[rk])) ? 32'd1 : 32'd0;
                core_pkg::OPC_ADDI:  res = regs[rj] + {{20{instr[21]}}, instr[21:10]};
                core_pkg::OPC_LU12I: res = {instr[24:5], 12'h000};
                core_pkg::OPC_BEQ: begin
                    wr    = 1'b0;
                    taken = (regs[rj] == regs[rd]);
                end
                core_pkg::OPC_BNE: begin
                    wr    = 1'b0;
                    taken = (regs[rj] != regs[rd]);
                end
                core_pkg::OPC_B: begin
                    wr    = 1'b0;
                    taken = 1'b1;
                end
                core_pkg::OPC_HALT: begin
                    wr       = 1'b0;
                    halt_hit = 1'b1;
                end
                default: wr = 1'b0;  // Undefined opcode
            endcase
            if (rd == 5'd0) wr = 1'b0;
            exp_pc.push_back(pc);
            exp_wen.push_back(wr ? 32'h0000_000f : 32'h0);
            exp_wnum.push_back(wr ? 32'(rd) : 32'h0);
            exp_wdata.push_back(wr ? res : 32'h0);
            exp_gap.push_back((steps == 0) ? 32'd0 : (prev_taken ? 32'd3 : 32'd1));
            exp_halt.push_back(halt_hit);
            if (wr) regs[rd] = res;
            pc         = taken ? pc + {{14{instr[25]}}, instr[25:10], 2'b00} : pc + 32'd4;
            prev_taken = taken;
            steps++;
        end
        if (!halt_hit) begin
            report_fail("Reference model ran 64 steps without reaching HALT");
        end
    endtask

    task automatic begin_test(input string name);
        $display("Running %s", name);
        @(posedge clk);
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        prog_len = 0;
    endtask

    task automatic run_program(input int post_cycles);
        int gap_cnt;
        bit done;
        run_model();
        #1 arst_n_i = 1'b1;
        gap_cnt = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            gap_cnt++;
            if (debug_commit_valid_o) begin
                if (exp_pc.size() == 0) begin
                    report_fail("Commit seen past the end of the expected program");
                end else begin
                    check_val("debug_wb_pc_o", exp_pc[0], debug_wb_pc_o);
                    check_val("debug_wb_rf_wen_o", exp_wen[0], 32'(debug_wb_rf_wen_o));
                    check_val("debug_wb_rf_wnum_o", exp_wnum[0], 32'(debug_wb_rf_wnum_o));
                    check_val("debug_wb_rf_wdata_o", exp_wdata[0], debug_wb_rf_wdata_o);
                    if (exp_gap[0] != 32'd0) begin
                        check_val("commit spacing", exp_gap[0], 32'(gap_cnt));
                    end
                    check_val("halted_o", exp_halt[0] ? 32'h1 : 32'h0, 32'(halted_o));
                    done = exp_halt[0];
                    void'(exp_pc.pop_front());
                    void'(exp_wen.pop_front());
                    void'(exp_wnum.pop_front());
                    void'(exp_wdata.pop_front());
                    void'(exp_gap.pop_front());
                    void'(exp_halt.pop_front());
                    gap_cnt = 0;
                end
            end
        end
        repeat (post_cycles) begin
            @(negedge clk);
            check_val("debug_commit_valid_o", 32'h0, 32'(debug_commit_valid_o));
            check_val("halted_o", 32'h1, 32'(halted_o));
            check_val("imem_req_o", 32'h0, 32'(imem_req_o));
        end
    endtask

    task automatic test_alu_ops;
        logic [31:0] up;
        logic [31:0] lo;
        begin_test("ALU register ops");
        for (int i = 1; i <= 4; i++) begin
            take_bits(20, up);
            take_bits(12, lo);
            if (i == 1) up[19] = 1'b0;  // Positive operand
            if (i == 2) up[19] = 1'b1;  // Negative operand for signed SLT
            emit(enc_u(i, up));
            emit(enc_i(i, i, lo));
        end
        emit(enc_r(core_pkg::OPC_ADD, 5, 1, 2));
        emit(enc_r(core_pkg::OPC_SUB, 6, 3, 4));
        emit(enc_r(core_pkg::OPC_AND, 7, 1, 3));
        emit(enc_r(core_pkg::OPC_OR, 8, 2, 4));
        emit(enc_r(core_pkg::OPC_XOR, 9, 1, 4));
        emit(enc_r(core_pkg::OPC_SLT, 10, 2, 1));
        emit(enc_r(core_pkg::OPC_SLT, 11, 1, 2));
        emit(enc_r(core_pkg::OPC_SLT, 12, 3, 4));
        emit(enc_r(core_pkg::OPC_SUB, 13, 2, 1));
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        run_program(3);
    endtask

    task automatic test_immediates;
        begin_test("Immediates");
        emit(enc_i(1, 0, -1));
        emit(enc_i(2, 0, -2048));
        emit(enc_i(3, 0, 2047));
        emit(enc_u(4, 'hfffff));
        emit(enc_u(5, 'h80000));
        emit(enc_i(6, 4, -5));
        emit(enc_i(7, 5, -2047));
        emit(enc_u(8, 1));
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        run_program(3);
    endtask

    task automatic test_dep_chain;
        logic [31:0] start;
        begin_test("Dependency chain");
        take_bits(32, start);
        emit(enc_u(1, start >> 12));
        emit(enc_i(1, 1, start));
        emit(enc_r(core_pkg::OPC_ADD, 2, 1, 1));
        emit(enc_r(core_pkg::OPC_SUB, 3, 2, 1));
        emit(enc_r(core_pkg::OPC_XOR, 4, 3, 2));
        emit(enc_i(4, 4, -7));
        emit(enc_r(core_pkg::OPC_OR, 5, 4, 1));
        emit(enc_r(core_pkg::OPC_AND, 6, 5, 4));
        emit(enc_r(core_pkg::OPC_SLT, 7, 6, 5));
        emit(enc_r(core_pkg::OPC_ADD, 8, 7, 6));
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        run_program(3);
    endtask

    task automatic test_branches;
        begin_test("Branches");
        emit(enc_i(1, 0, 3));                     // Loop count
        emit(enc_i(2, 0, 0));
        emit(enc_i(3, 0, 5));
        emit(enc_br(core_pkg::OPC_BEQ, 3, 1, 2));  // Not taken
        emit(enc_i(4, 0, 11));
        emit(enc_br(core_pkg::OPC_BNE, 3, 1, 2));  // Taken
        emit(enc_i(4, 0, 99));
        emit(enc_i(5, 3, 0));
        emit(enc_br(core_pkg::OPC_BEQ, 5, 3, 3));  // Taken, skips two
        emit(enc_i(6, 0, 77));
        emit(enc_i(7, 0, 88));
        emit(enc_br(core_pkg::OPC_BNE, 5, 3, 2));  // Not taken
        emit(enc_i(6, 0, 1));
        emit(enc_i(2, 2, 1));                     // Loop body
        emit(enc_i(1, 1, -1));
        emit(enc_br(core_pkg::OPC_BNE, 1, 0, -2)); // Backward
        emit(enc_i(8, 2, 0));
        emit(enc_br(core_pkg::OPC_B, 0, 0, 2));
        emit(enc_i(9, 0, 55));
        emit(enc_i(10, 2, 100));
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        run_program(3);
    endtask

    task automatic test_r0_noop;
        begin_test("r0 and no-ops");
        emit(enc_i(0, 0, 123));
        emit(enc_u(0, 'h12345));
        emit(enc_r(core_pkg::OPC_ADD, 1, 0, 0));
        emit(enc_i(2, 0, 45));
        emit(enc_r(6'h07, 3, 1, 2));              // Undefined opcode
        emit(enc_r(6'h20, 9, 2, 2));
        emit(enc_r(core_pkg::OPC_OR, 3, 2, 0));
        emit(enc_r(core_pkg::OPC_ADD, 0, 2, 2));
        emit(enc_r(core_pkg::OPC_ADD, 4, 0, 2));  // r0 right after a write to it
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        run_program(3);
    endtask

    task automatic test_halt;
        begin_test("Halt");
        emit(enc_i(1, 0, 1));
        emit(enc_i(2, 0, 2));
        emit(enc_br(core_pkg::OPC_HALT, 0, 0, 0));
        emit(enc_i(3, 0, 3));
        emit(enc_i(4, 0, 4));
        run_program(20);
    endtask

    // Instruction memory, answers one cycle after the request
    always begin
        @(negedge clk);
        req_q  = imem_req_o;
        addr_q = imem_addr_o;
        @(posedge clk);
        #1;
        if (req_q) imem_rdata_i = mem_word(addr_q);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles) begin
            report_fail($sformatf("Timeout, run went past %0d cycles", max_cycles));
        end
    end

    initial begin
        arst_n_i     = 1'b0;
        imem_rdata_i = '0;
        lfsr_q       = lfsr_seed;
        prog_len     = 0;
        cycle_cnt    = 0;
        test_alu_ops();
        test_immediates();
        test_dep_chain();
        test_branches();
        test_r0_noop();
        test_halt();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_ctrl.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/exec_unit.sv
verilog/core_top.sv
verif/tb_clkgen.sv
verif/core_props.sv
verif/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module core_tb -Mdir obj_dir; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
